// File: logic/iw_pkg.sv
package iw_pkg;

    // physical register tag, 32 physical registers
    localparam int tag_w = 5;
    // sequence id carried for ordering checks downstream
    localparam int seq_w = 8;
    localparam int op_w  = 4;
    localparam int imm_w = 16;

    // slots in the window unless the top level overrides it
    localparam int default_depth = 8;

    // decoded and renamed instruction, 45 bits
    typedef struct packed {
        logic [seq_w-1:0] seq;
        logic [op_w-1:0]  op;
        logic [tag_w-1:0] src1;
        logic [tag_w-1:0] src2;
        logic             use_src1;
        logic             use_src2;
        logic [tag_w-1:0] dst;
        logic [imm_w-1:0] imm;
    } iw_instr_t;

    // instruction as held in a window slot, 47 bits
    typedef struct packed {
        iw_instr_t instr;
        logic      src1_rdy;
        logic      src2_rdy;
    } iw_entry_t;

    // writeback broadcast from the execution side
    typedef struct packed {
        logic             valid;
        logic [tag_w-1:0] tag;
    } iw_wb_t;

endpackage

// File: logic/iw_dispatch.sv
`timescale 1ns/1ps

module iw_dispatch #(
    parameter int num_pregs = 2 ** iw_pkg::tag_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  iw_pkg::iw_instr_t in_instr,
    output logic              in_ready,
    input  logic              space,
    input  iw_pkg::iw_wb_t    wb,
    output logic              push,
    output iw_pkg::iw_entry_t push_entry
);

    // one bit per physical register, set while a producer is in flight
    logic [num_pregs-1:0] busy;
    logic [num_pregs-1:0] busy_next;

    // window decides whether an entry fits this cycle
    assign in_ready = space;
    assign push     = in_valid && in_ready;

    // entry formation
    // lookup uses the registered scoreboard only, a writeback in this
    // same cycle is picked up by the slot wakeup when the entry loads
    always_comb begin
        push_entry.instr    = in_instr;
        push_entry.src1_rdy = !in_instr.use_src1 || !busy[in_instr.src1];
        push_entry.src2_rdy = !in_instr.use_src2 || !busy[in_instr.src2];
    end

    // scoreboard update, set applied last so it wins over a clear
    always_comb begin
        busy_next = busy;
        if (wb.valid) begin
            busy_next[wb.tag] = 1'b0;
        end
        if (push) begin
            busy_next[in_instr.dst] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy <= '0;
        end else begin
            busy <= busy_next;
        end
    end

    // renamer only hands out free registers
    // a register freed by a writeback in this very cycle may be reused
    a_dst_not_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        push |-> (!busy[in_instr.dst] || (wb.valid && wb.tag == in_instr.dst))
    ) else $error("dispatch: destination tag %0h pushed while busy", in_instr.dst);

    // every writeback must match an earlier dispatched destination
    a_wb_was_busy : assert property (
        @(posedge clk) disable iff (!rst_n)
        wb.valid |-> busy[wb.tag]
    ) else $error("dispatch: writeback to tag %0h that is not busy", wb.tag);

endmodule

// File: logic/iw_slot.sv
`timescale 1ns/1ps

module iw_slot (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              shift,
    input  logic              load,
    input  logic              clear,
    input  iw_pkg::iw_entry_t above,
    input  logic              above_valid,
    input  iw_pkg::iw_entry_t push_entry,
    input  iw_pkg::iw_wb_t    wb,
    output logic              valid,
    output logic              ready,
    output iw_pkg::iw_entry_t entry
);

    // entry this slot keeps for the next cycle before wakeup
    iw_pkg::iw_entry_t keep;
    // same entry with the writeback applied
    iw_pkg::iw_entry_t woken;

    always_comb begin
        if (load) begin
            keep = push_entry;
        end else if (shift) begin
            keep = above;
        end else begin
            keep = entry;
        end
    end

    // wakeup on a tag match also covers an entry arriving this cycle
    always_comb begin
        woken = keep;
        if (wb.valid && keep.instr.src1 == wb.tag) begin
            woken.src1_rdy = 1'b1;
        end
        if (wb.valid && keep.instr.src2 == wb.tag) begin
            woken.src2_rdy = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid <= 1'b0;
        end else if (load) begin
            valid <= 1'b1;
        end else if (clear) begin
            valid <= 1'b0;
        end else if (shift) begin
            valid <= above_valid;
        end
    end

    // payload follows load, shift or hold with wakeup applied
    always_ff @(posedge clk) begin
        entry <= woken;
    end

    assign ready = valid && entry.src1_rdy && entry.src2_rdy;

    // scheduler drops the shift wherever it places the new entry
    a_no_load_and_shift : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(load && shift)
    ) else $error("slot: load and shift raised together");

endmodule

// File: logic/iw_scheduler.sv
`timescale 1ns/1ps

module iw_scheduler #(
    parameter int window_depth = iw_pkg::default_depth
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [window_depth-1:0] slot_valid,
    input  logic [window_depth-1:0] slot_ready,
    input  iw_pkg::iw_entry_t       slot_entry [window_depth-1:0],
    input  logic                    push,
    output logic                    space,
    output logic [window_depth-1:0] shift,
    output logic [window_depth-1:0] load,
    output logic [window_depth-1:0] clear,
    output logic                    iss_valid,
    output iw_pkg::iw_instr_t       iss_instr,
    input  logic                    iss_ready
);

    localparam int idx_w = $clog2(window_depth);
    localparam int cnt_w = $clog2(window_depth + 1);

    logic [idx_w-1:0]        sel;
    logic [cnt_w-1:0]        count;
    logic [cnt_w-1:0]        load_idx;
    logic                    go;
    logic [window_depth-1:0] valid_inc;

    // lowest index is the oldest, so scan down and keep the last hit
    always_comb begin
        sel = '0;
        for (int i = window_depth - 1; i >= 0; i--) begin
            if (slot_ready[i]) begin
                sel = idx_w'(i);
            end
        end
    end

    always_comb begin
        count = '0;
        for (int i = 0; i < window_depth; i++) begin
            count = count + cnt_w'(slot_valid[i]);
        end
    end

    assign iss_valid = |slot_ready;
    assign iss_instr = slot_entry[sel].instr;
    assign go        = iss_valid && iss_ready;

    // window full only blocks when nothing leaves this cycle
    assign space = !(&slot_valid) || go;

    // first free index once the issued slot has been squeezed out
    assign load_idx = go ? count - 1'b1 : count;

    always_comb begin
        for (int i = 0; i < window_depth; i++) begin
            load[i]  = push && (cnt_w'(i) == load_idx);
            shift[i] = go && (idx_w'(i) >= sel) && !load[i];
            clear[i] = 1'b0;
        end
        // nothing above the top slot to copy down
        clear[window_depth-1] = shift[window_depth-1];
    end

    // all-ones run from bit 0 plus one leaves no overlap
    assign valid_inc = slot_valid + 1'b1;

    a_issue_from_valid : assert property (
        @(posedge clk) disable iff (!rst_n)
        go |-> slot_valid[sel]
    ) else $error("scheduler: issued slot %0d is not valid", sel);

    a_compacted : assert property (
        @(posedge clk) disable iff (!rst_n)
        (valid_inc & slot_valid) == '0
    ) else $error("scheduler: valid slots not contiguous, %b", slot_valid);

endmodule

// File: logic/iw_top.sv
`timescale 1ns/1ps

module iw_top #(
    parameter int window_depth = iw_pkg::default_depth,
    parameter int num_pregs    = 2 ** iw_pkg::tag_w
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              in_valid,
    input  iw_pkg::iw_instr_t in_instr,
    output logic              in_ready,
    input  iw_pkg::iw_wb_t    wb,
    output logic              iss_valid,
    output iw_pkg::iw_instr_t iss_instr,
    input  logic              iss_ready
);

    logic                    push;
    iw_pkg::iw_entry_t       push_entry;
    logic                    space;
    logic [window_depth-1:0] shift;
    logic [window_depth-1:0] load;
    logic [window_depth-1:0] clear;
    logic [window_depth-1:0] slot_valid;
    logic [window_depth-1:0] slot_ready;
    iw_pkg::iw_entry_t       slot_entry [window_depth-1:0];

    iw_dispatch #(
        .num_pregs (num_pregs)
    ) u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_instr   (in_instr),
        .in_ready   (in_ready),
        .space      (space),
        .wb         (wb),
        .push       (push),
        .push_entry (push_entry)
    );

    // collapsing window, slot 0 holds the oldest entry
    for (genvar i = 0; i < window_depth; i++) begin : g_slot
        iw_pkg::iw_entry_t above;
        logic              above_valid;

        if (i == window_depth - 1) begin : g_top
            assign above       = '0;
            assign above_valid = 1'b0;
        end else begin : g_mid
            assign above       = slot_entry[i+1];
            assign above_valid = slot_valid[i+1];
        end

        iw_slot u_slot (
            .clk         (clk),
            .rst_n       (rst_n),
            .shift       (shift[i]),
            .load        (load[i]),
            .clear       (clear[i]),
            .above       (above),
            .above_valid (above_valid),
            .push_entry  (push_entry),
            .wb          (wb),
            .valid       (slot_valid[i]),
            .ready       (slot_ready[i]),
            .entry       (slot_entry[i])
        );
    end

    iw_scheduler #(
        .window_depth (window_depth)
    ) u_scheduler (
        .clk        (clk),
        .rst_n      (rst_n),
        .slot_valid (slot_valid),
        .slot_ready (slot_ready),
        .slot_entry (slot_entry),
        .push       (push),
        .space      (space),
        .shift      (shift),
        .load       (load),
        .clear      (clear),
        .iss_valid  (iss_valid),
        .iss_instr  (iss_instr),
        .iss_ready  (iss_ready)
    );

endmodule

// File: verif/iw_checker.sv
`timescale 1ns/1ps

module iw_checker (
    input logic              clk,
    input logic              rst_n,
    input logic              iss_valid,
    input logic              iss_ready,
    input iw_pkg::iw_instr_t iss_instr
);

    // expected issue order filled by the testbench for each case
    iw_pkg::iw_instr_t exp_q [$];
    int transfers;
    int mismatches;
    int other_errors;

    iw_pkg::iw_instr_t want;
    logic              stalled;

    initial begin
        transfers    = 0;
        mismatches   = 0;
        other_errors = 0;
        stalled      = 1'b0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            stalled <= 1'b0;
        end else begin
            if ($isunknown(iss_valid)) begin
                other_errors++;
                $display("issue valid is unknown at time %0t", $time);
            end
            // nothing leaves during a stall, so the offer must stay up
            if (stalled && !iss_valid) begin
                other_errors++;
                $display("issue valid dropped during a stall at time %0t", $time);
            end
            stalled <= iss_valid && !iss_ready;
            if (iss_valid && iss_ready) begin
                transfers++;
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("unexpected issue of seq %h with no issue left to expect",
                             iss_instr.seq);
                end else begin
                    want = exp_q.pop_front();
                    if (iss_instr.seq !== want.seq) begin
                        mismatches++;
                        $display("MISMATCH iss_instr.seq got %h expected %h",
                                 iss_instr.seq, want.seq);
                    end else if (iss_instr !== want) begin
                        mismatches++;
                        $display("MISMATCH iss_instr got %h expected %h",
                                 iss_instr, want);
                    end
                end
            end
        end
    end

endmodule

// File: verif/iw_tb.sv
`timescale 1ns/1ps

module iw_tb;

    localparam int depth = iw_pkg::default_depth;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    iw_pkg::iw_instr_t in_instr;
    logic              in_ready;
    iw_pkg::iw_wb_t    wb;
    logic              iss_valid;
    iw_pkg::iw_instr_t iss_instr;
    logic              iss_ready;

    logic [15:0]       mem [0:1023];
    logic [31:0]       lfsr;
    iw_pkg::iw_instr_t instr_q [$];
    int                wb_off_q [$];
    logic [4:0]        wb_tag_q [$];
    int                stall_mode;
    int                expect_full;
    int                in_stalls;
    int                tb_errors;
    int                limit;
    int                ptr;
    int                total_errors;
    bit                case_done;

    always #10 clk = ~clk;

    iw_top #(
        .window_depth (depth),
        .num_pregs    (32)
    ) dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .in_ready  (in_ready),
        .wb        (wb),
        .iss_valid (iss_valid),
        .iss_instr (iss_instr),
        .iss_ready (iss_ready)
    );

    iw_checker chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss_instr (iss_instr)
    );

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // instructions plus writeback offsets over every case
    function automatic int count_budget();
        int p;
        int n;
        p = 0;
        n = 0;
        while (mem[p] === 16'h1) begin
            n += mem[p+3];
            p += 8 + 8 * mem[p+3];
            while (mem[p] === 16'h3) begin
                n += mem[p+1];
                p += 8;
            end
            while (mem[p] === 16'h4) begin
                p += 8;
            end
        end
        return n;
    endfunction

    // whole instruction of the case that carries this sequence id
    task automatic push_expected(input logic [iw_pkg::seq_w-1:0] seq);
        int hits;
        hits = 0;
        foreach (instr_q[i]) begin
            if (instr_q[i].seq == seq) begin
                chk.exp_q.push_back(instr_q[i]);
                hits++;
            end
        end
        if (hits != 1) begin
            tb_errors++;
            $display("expected seq %h matches %0d instructions of the case", seq, hits);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        if (iss_valid !== 1'b0) begin
            tb_errors++;
            $display("issue valid is not low after reset");
        end
        if (in_ready !== 1'b1) begin
            tb_errors++;
            $display("input ready is not high after reset");
        end
    endtask

    task automatic drive_instrs();
        foreach (instr_q[i]) begin
            in_valid = 1'b1;
            in_instr = instr_q[i];
            forever begin
                @(posedge clk);
                if (in_ready) begin
                    break;
                end
                in_stalls++;
            end
            #1;
        end
        in_valid = 1'b0;
        in_instr = '0;
    endtask

    // offsets count edges from the first drive cycle in rising order
    task automatic drive_wbs();
        int now;
        now = 0;
        foreach (wb_off_q[i]) begin
            repeat (wb_off_q[i] - now) @(posedge clk);
            #1 wb.valid = 1'b1;
            wb.tag = wb_tag_q[i];
            @(posedge clk);
            #1 wb = '0;
            now = wb_off_q[i] + 1;
        end
    endtask

    task automatic drive_ready();
        while (!case_done) begin
            if (stall_mode != 0) begin
                lfsr = lfsr_next(lfsr);
                iss_ready = lfsr[0];
            end else begin
                iss_ready = 1'b1;
            end
            @(posedge clk);
            #1;
        end
        iss_ready = 1'b1;
    endtask

    task automatic run_case(inout int p);
        int n_instr;
        int n_wb;
        iw_pkg::iw_instr_t ins;
        stall_mode  = mem[p+2];
        n_instr     = mem[p+3];
        n_wb        = mem[p+4];
        expect_full = mem[p+5];
        p += 8;
        instr_q.delete();
        wb_off_q.delete();
        wb_tag_q.delete();
        for (int i = 0; i < n_instr; i++) begin
            ins.seq      = mem[p+1][7:0];
            ins.src1     = mem[p+2][4:0];
            ins.src2     = mem[p+3][4:0];
            ins.use_src1 = mem[p+4][1];
            ins.use_src2 = mem[p+4][0];
            ins.dst      = mem[p+5][4:0];
            ins.op       = mem[p+6][3:0];
            ins.imm      = mem[p+7];
            instr_q.push_back(ins);
            p += 8;
        end
        for (int i = 0; i < n_wb; i++) begin
            wb_off_q.push_back(int'(mem[p+1]));
            wb_tag_q.push_back(mem[p+2][4:0]);
            p += 8;
        end
        while (mem[p] === 16'h4) begin
            for (int j = 0; j < mem[p+1]; j++) begin
                push_expected(mem[p+2+j][7:0]);
            end
            p += 8;
        end
        apply_reset();
        in_stalls = 0;
        case_done = 1'b0;
        fork
            drive_ready();
            begin
                fork
                    drive_instrs();
                    drive_wbs();
                join
                while (chk.exp_q.size() != 0) begin
                    @(posedge clk);
                end
                // a few idle cycles to catch any extra issue
                repeat (3) @(posedge clk);
                case_done = 1'b1;
            end
        join
        if (expect_full != 0 && in_stalls == 0) begin
            tb_errors++;
            $display("input ready never dropped while the window was full");
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;
        wb        = '0;
        iss_ready = 1'b0;
        lfsr      = 32'heda8;
        tb_errors = 0;
        case_done = 1'b0;
        $readmemh("verif/iw_cases.txt", mem);
        limit = (count_budget() + 20) * depth;
        fork
            begin
                repeat (limit) @(posedge clk);
                $display("timeout after %0d cycles, %0d expected issues never arrived",
                         limit, chk.exp_q.size());
                $display("Checks failed");
                $finish;
            end
        join_none
        ptr = 0;
        while (mem[ptr] === 16'h1) begin
            run_case(ptr);
        end
        total_errors = tb_errors + chk.mismatches + chk.other_errors;
        $display("transfers=%0d mismatches=%0d other_errors=%0d",
                 chk.transfers, chk.mismatches, tb_errors + chk.other_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/iw_pkg.sv
logic/iw_dispatch.sv
logic/iw_slot.sv
logic/iw_scheduler.sv
logic/iw_top.sv
verif/iw_checker.sv
verif/iw_tb.sv

// File: verif/iw_cases.txt
// 1 case: id stall_mode n_instr n_wb expect_full 0 0
// 2 instr: seq src1 src2 use(src1 src2) dst op imm | 3 wb: offset tag
// 4 expected: count then up to six seq ids in issue order | 0 end
1 1 0 4 0 0 0 0
2 01 00 00 0 01 1 0010
2 02 00 00 0 02 1 0020
2 03 00 00 0 03 2 0030
2 04 00 00 0 04 3 0040
4 4 01 02 03 04 0 0
1 2 0 4 1 0 0 0
2 10 00 00 0 05 1 0100
2 11 05 00 2 06 2 0101
2 12 00 00 0 07 3 0102
2 13 00 00 0 08 4 0103
3 08 05 0 0 0 0 0
4 4 10 12 13 11 0 0
1 3 0 3 1 0 0 0
2 20 00 00 0 09 1 0200
2 21 09 00 2 0a 2 0201
2 22 00 00 0 0b 3 0202
3 01 09 0 0 0 0 0
4 3 20 21 22 0 0 0
1 4 0 a 1 1 0 0
2 30 00 00 0 0a 1 0300
2 31 0a 00 2 0b 2 0301
2 32 0a 00 2 0c 2 0302
2 33 0a 00 2 0d 2 0303
2 34 0a 00 2 0e 2 0304
2 35 0a 00 2 0f 2 0305
2 36 0a 00 2 10 2 0306
2 37 0a 00 2 11 2 0307
2 38 0a 00 2 12 2 0308
2 39 00 00 0 13 5 0309
3 0e 0a 0 0 0 0 0
4 6 30 31 32 33 34 35
4 4 36 37 38 39 0 0
1 5 1 8 1 0 0 0
2 50 00 00 0 14 1 0500
2 51 01 02 3 15 2 0501
2 52 01 02 3 16 3 0502
2 53 01 02 3 17 4 0503
2 54 01 02 3 18 5 0504
2 55 01 02 3 19 6 0505
2 56 01 02 3 1a 7 0506
2 57 14 00 2 1b 8 0507
3 06 14 0 0 0 0 0
4 6 50 51 52 53 54 55
4 2 56 57 0 0 0 0
0 0 0 0 0 0 0 0
